/* verilog.f */
+incdir+source
source/soc_pkg.sv
source/soc_addr_decode.sv
source/soc_l2_mem.sv
source/soc_ctrl_regs.sv
source/soc_apb_bridge.sv
source/soc_top.sv
verif/soc_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SoC interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -rf "$BUILD"

verilator --binary --timing --assert -Wno-fatal --top-module soc_tb \
  -f verilog.f -Mdir "$BUILD" -o soc_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD/soc_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

/* verif/soc_tb.sv */
// Testbench for the SoC interconnect
// Host stimulus, APB slave model, reference model, assertions and watchdog

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_tb import soc_pkg::*;;

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int L2_WORDS_USED = 16;
  localparam int UART_XFERS    = 12;
  // Per-test cycle budgets with at most 6 cycles per APB transfer
  localparam int TEST_CYCLES = (RESET_CYCLES + 2) + (3 * L2_WORDS_USED + 3) + (9 + 3)
                             + (2 * UART_XFERS * 6 + 3) + (8 + 3);
  localparam logic [11:0] EXIT_OFS = 12'(`SOC_CTRL_EXIT_OFS);
  localparam logic [11:0] CNT_OFS  = 12'(`SOC_CTRL_CNT_OFS);

  logic                       clk;
  logic                       reset;
  logic                       host_req;
  logic                       host_we;
  logic [`SOC_ADDR_W-1:0]     host_addr;
  logic [`SOC_STRB_W-1:0]     host_be;
  logic [`SOC_DATA_W-1:0]     host_wdata;
  logic                       host_gnt;
  logic                       host_rvalid;
  logic [`SOC_DATA_W-1:0]     host_rdata;
  logic                       host_err;
  logic [`SOC_DATA_W-1:0]     exit_val;
  logic [`SOC_DATA_W-1:0]     cnt_en_val;
  logic                       uart_psel;
  logic                       uart_penable;
  logic                       uart_pwrite;
  logic [`SOC_ADDR_W-1:0]     uart_paddr;
  logic [`SOC_APB_DATA_W-1:0] uart_pwdata;
  logic [`SOC_APB_DATA_W-1:0] uart_prdata;
  logic                       uart_pready;
  logic                       uart_pslverr;

  // Reference model state
  logic [`SOC_DATA_W-1:0]     l2_model [`SOC_L2_WORDS];
  logic [`SOC_DATA_W-1:0]     exit_model;
  logic [`SOC_DATA_W-1:0]     cnt_model;
  logic [`SOC_APB_DATA_W-1:0] apb_mem [16];
  int unsigned                apb_wait;
  logic [`SOC_DATA_W-1:0]     exp_rdata_q [$];
  logic                       exp_err_q [$];
  logic                       exp_valid;
  logic [`SOC_DATA_W-1:0]     exp_rdata;
  logic                       exp_err;
  soc_target_e                req_tgt;
  logic [`SOC_ADDR_W-1:0]     l2_probe_addr;
  int                         cyc = 0;
  int                         err_cnt = 0;
  int                         tests_run = 0;
  int                         tests_failed = 0;

  soc_top uut (
    .clk_i(clk), .reset_i(reset),
    .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_be_i(host_be), .host_wdata_i(host_wdata), .host_gnt_o(host_gnt),
    .host_rvalid_o(host_rvalid), .host_rdata_o(host_rdata), .host_err_o(host_err),
    .exit_o(exit_val), .hw_cnt_en_o(cnt_en_val),
    .uart_penable_o(uart_penable), .uart_pwrite_o(uart_pwrite), .uart_paddr_o(uart_paddr),
    .uart_psel_o(uart_psel), .uart_pwdata_o(uart_pwdata), .uart_prdata_i(uart_prdata),
    .uart_pready_i(uart_pready), .uart_pslverr_i(uart_pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Memory map as seen by the host
  function automatic soc_target_e region(input logic [`SOC_ADDR_W-1:0] a);
    if (a >= `SOC_DRAM_BASE && a < `SOC_DRAM_BASE + `SOC_DRAM_LEN) return T_L2;
    if (a >= `SOC_UART_BASE && a < `SOC_UART_BASE + `SOC_UART_LEN) return T_UART;
    if (a >= `SOC_CTRL_BASE && a < `SOC_CTRL_BASE + `SOC_CTRL_LEN) return T_CTRL;
    return T_NONE;
  endfunction

  function automatic logic [`SOC_DATA_W-1:0] byte_mask(input logic [`SOC_STRB_W-1:0] be);
    logic [`SOC_DATA_W-1:0] m;
    for (int i = 0; i < `SOC_STRB_W; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  always_comb req_tgt = region(host_addr);

  //////////////////////////////
  // Expected responses
  //////////////////////////////

  always @(posedge clk) begin
    logic [`SOC_DATA_W-1:0] rd;
    logic                   er;
    logic [`SOC_DATA_W-1:0] m;
    logic [9:0]             idx;
    cyc <= cyc + 1;
    if (reset) begin
      exit_model <= '0;
      cnt_model  <= '0;
      exp_valid  <= 1'b0;
      exp_rdata_q.delete();
      exp_err_q.delete();
    end else begin
      if (host_rvalid && exp_rdata_q.size() > 0) begin
        void'(exp_rdata_q.pop_front());
        void'(exp_err_q.pop_front());
      end
      if (host_gnt) begin
        rd  = '0;
        er  = 1'b0;
        m   = byte_mask(host_be);
        idx = host_addr[12:3];
        case (req_tgt)
          T_L2: begin
            if (host_we) l2_model[idx] = (l2_model[idx] & ~m) | (host_wdata & m);
            else rd = l2_model[idx];
          end
          T_CTRL: begin
            if (host_addr[11:0] == EXIT_OFS) begin
              if (host_we) exit_model <= (exit_model & ~m) | (host_wdata & m);
              else rd = exit_model;
            end else if (host_addr[11:0] == CNT_OFS) begin
              if (host_we) cnt_model <= (cnt_model & ~m) | (host_wdata & m);
              else rd = cnt_model;
            end
          end
          T_UART: begin
            if (!host_we) rd = {32'h0, uart_prdata};
            er = uart_pslverr;
          end
          default: er = 1'b1;
        endcase
        exp_rdata_q.push_back(rd);
        exp_err_q.push_back(er);
      end
      exp_valid <= (exp_rdata_q.size() > 0);
      if (exp_rdata_q.size() > 0) begin
        exp_rdata <= exp_rdata_q[0];
        exp_err   <= exp_err_q[0];
      end
    end
  end

  // APB slave with 0 to 3 wait states and pslverr from offset 0x800
  always @(posedge clk) begin
    int unsigned w;
    if (reset) begin
      uart_pready <= 1'b0;
      apb_wait    <= 0;
    end else if (uart_psel && uart_penable && uart_pready) begin
      uart_pready <= 1'b0;
      if (uart_pwrite && uart_paddr[11:0] < 12'h800) apb_mem[uart_paddr[5:2]] <= uart_pwdata;
    end else if (uart_psel) begin
      w = uart_penable ? apb_wait : $urandom_range(3, 0);
      if (w == 0) begin
        uart_pready  <= 1'b1;
        uart_pslverr <= (uart_paddr[11:0] >= 12'h800);
        uart_prdata  <= apb_mem[uart_paddr[5:2]];
      end else begin
        apb_wait <= w - 1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  a_reset: assert property (@(posedge clk) (cyc > 0 && (reset || $past(reset))) |->
      (!host_gnt && !host_rvalid && !uart_psel && !uart_penable &&
       exit_val == '0 && cnt_en_val == '0))
    else flag_error("outputs not idle around reset");
  a_gnt_now: assert property (@(posedge clk) disable iff (reset)
      host_req && req_tgt != T_UART |-> host_gnt)
    else flag_error("non-UART request not granted in its cycle");
  a_rsp_slot: assert property (@(posedge clk) disable iff (reset)
      host_rvalid == $past(host_gnt))
    else flag_error("rvalid not exactly one cycle after grant");
  a_rsp_data: assert property (@(posedge clk) disable iff (reset)
      host_rvalid |-> exp_valid && host_rdata == exp_rdata && host_err == exp_err)
    else flag_error($sformatf("response %h err %b, expected %h err %b",
                              host_rdata, host_err, exp_rdata, exp_err));
  a_ctrl_out: assert property (@(posedge clk) disable iff (reset)
      exit_val == exit_model && cnt_en_val == cnt_model)
    else flag_error("exit or hw_cnt_en output differs from model");
  a_apb_setup: assert property (@(posedge clk) disable iff (reset)
      $past(uart_psel && !uart_penable) |-> uart_psel && uart_penable)
    else flag_error("APB SETUP not followed by ACCESS");
  a_apb_one_setup: assert property (@(posedge clk) disable iff (reset)
      uart_psel && !uart_penable |-> !$past(uart_psel))
    else flag_error("APB SETUP longer than one cycle");
  a_apb_hold: assert property (@(posedge clk) disable iff (reset)
      uart_penable |-> uart_paddr == $past(uart_paddr) && uart_pwrite == $past(uart_pwrite) &&
                       uart_pwdata == $past(uart_pwdata) && $past(uart_psel))
    else flag_error("APB fields changed during ACCESS");
  a_apb_fields: assert property (@(posedge clk) disable iff (reset)
      uart_psel |-> host_req && uart_paddr == host_addr && uart_pwrite == host_we &&
                    uart_pwdata == host_wdata[`SOC_APB_DATA_W-1:0])
    else flag_error("APB fields do not match the host request");
  a_apb_gnt: assert property (@(posedge clk) disable iff (reset)
      host_gnt && req_tgt == T_UART |-> uart_penable && uart_pready)
    else flag_error("UART grant without pready in ACCESS");
  a_apb_release: assert property (@(posedge clk) disable iff (reset)
      $past(uart_penable && uart_pready) |-> !uart_psel)
    else flag_error("psel still high after APB completion");

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic bus_access(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                            input logic [`SOC_STRB_W-1:0] be,
                            input logic [`SOC_DATA_W-1:0] wdata);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_be    <= be;
    host_wdata <= wdata;
    @(posedge clk);
    while (!host_gnt) begin
      @(posedge clk);
    end
  endtask

  task automatic idle_cycles(input int cycles);
    host_req <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int first_err);
    int n;
    n = err_cnt - first_err;
    tests_run++;
    if (n == 0) begin
      $display("test %-10s ok", name);
    end else begin
      tests_failed++;
      $display("test %-10s failed with %0d errors", name, n);
    end
  endtask

  task automatic l2_write_read;
    logic [`SOC_ADDR_W-1:0] addr [L2_WORDS_USED];
    int                     first_err;
    int unsigned            idx;
    first_err = err_cnt;
    for (int k = 0; k < L2_WORDS_USED; k++) begin
      idx = k * 64 + $urandom_range(63, 0);
      addr[k] = `SOC_DRAM_BASE + (idx << 3);
      bus_access(1'b1, addr[k], 8'hff, {$urandom, $urandom});
    end
    for (int k = 0; k < L2_WORDS_USED; k++) begin
      bus_access(1'b1, addr[k], 8'($urandom), {$urandom, $urandom});
    end
    for (int k = 0; k < L2_WORDS_USED; k++) begin
      bus_access(1'b0, addr[k], 8'h00, '0);
    end
    l2_probe_addr = addr[0];
    idle_cycles(3);
    report_test("l2", first_err);
  endtask

  task automatic ctrl_reg_access;
    int first_err;
    first_err = err_cnt;
    bus_access(1'b1, `SOC_CTRL_BASE + EXIT_OFS, 8'h0f, {$urandom, $urandom});
    bus_access(1'b1, `SOC_CTRL_BASE + CNT_OFS, 8'hff, {$urandom, $urandom});
    bus_access(1'b1, `SOC_CTRL_BASE + EXIT_OFS, 8'hc0, {$urandom, $urandom});
    bus_access(1'b1, `SOC_CTRL_BASE + 32'h10, 8'hff, {$urandom, $urandom});
    bus_access(1'b1, `SOC_CTRL_BASE + 32'h800, 8'hff, {$urandom, $urandom});
    bus_access(1'b0, `SOC_CTRL_BASE + EXIT_OFS, 8'h00, '0);
    bus_access(1'b0, `SOC_CTRL_BASE + CNT_OFS, 8'h00, '0);
    bus_access(1'b0, `SOC_CTRL_BASE + 32'h10, 8'h00, '0);
    bus_access(1'b0, `SOC_CTRL_BASE + 32'h800, 8'h00, '0);
    idle_cycles(3);
    report_test("ctrl", first_err);
  endtask

  task automatic uart_transfers;
    logic [`SOC_ADDR_W-1:0] ofs [UART_XFERS];
    int                     first_err;
    first_err = err_cnt;
    // Every fourth transfer lands in the error range
    for (int k = 0; k < UART_XFERS; k++) begin
      ofs[k] = (k % 4 == 3) ? 32'h800 + 32'(k * 4) : $urandom_range(15, 0) * 4;
      bus_access(1'b1, `SOC_UART_BASE + ofs[k], 8'hff, {$urandom, $urandom});
    end
    for (int k = 0; k < UART_XFERS; k++) begin
      bus_access(1'b0, `SOC_UART_BASE + ofs[k], 8'h00, '0);
    end
    idle_cycles(3);
    report_test("uart", first_err);
  endtask

  task automatic unmapped_access;
    int first_err;
    first_err = err_cnt;
    bus_access(1'b1, 32'h0000_1000, 8'hff, {$urandom, $urandom});
    // Would alias onto the probe word if the L2 window were too wide
    bus_access(1'b1, l2_probe_addr + 32'h2000, 8'hff, {$urandom, $urandom});
    bus_access(1'b1, 32'hd000_1008, 8'hff, {$urandom, $urandom});
    bus_access(1'b0, 32'hc000_1000, 8'h00, '0);
    bus_access(1'b0, 32'hffff_fff8, 8'h00, '0);
    bus_access(1'b0, l2_probe_addr, 8'h00, '0);
    bus_access(1'b0, `SOC_CTRL_BASE + EXIT_OFS, 8'h00, '0);
    bus_access(1'b0, `SOC_CTRL_BASE + CNT_OFS, 8'h00, '0);
    idle_cycles(3);
    report_test("unmapped", first_err);
  endtask

  initial begin
    int first_err;
    void'($urandom(32'hfd7f_9b7d));
    reset        = 1'b1;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_be      = '0;
    host_wdata   = '0;
    uart_prdata  = '0;
    uart_pready  = 1'b0;
    uart_pslverr = 1'b0;
    for (int i = 0; i < 16; i++) begin
      apb_mem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0101_0101);
    end
    first_err = err_cnt;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(2);
    report_test("reset", first_err);
    l2_write_read();
    ctrl_reg_access();
    uart_transfers();
    unmapped_access();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TEST_CYCLES * 4) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : soc_tb

/* source/soc_top.sv */
// SoC interconnect top level
// Address decoder, L2 SRAM, control registers and UART APB bridge

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Host bus
  input  logic                       host_req_i,
  input  logic                       host_we_i,
  input  logic [`SOC_ADDR_W-1:0]     host_addr_i,
  input  logic [`SOC_STRB_W-1:0]     host_be_i,
  input  logic [`SOC_DATA_W-1:0]     host_wdata_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [`SOC_DATA_W-1:0]     host_rdata_o,
  output logic                       host_err_o,
  // Control outputs
  output logic [`SOC_DATA_W-1:0]     exit_o,
  output logic [`SOC_DATA_W-1:0]     hw_cnt_en_o,
  // UART APB interface
  output logic                       uart_penable_o,
  output logic                       uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0]     uart_paddr_o,
  output logic                       uart_psel_o,
  output logic [`SOC_APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [`SOC_APB_DATA_W-1:0] uart_prdata_i,
  input  logic                       uart_pready_i,
  input  logic                       uart_pslverr_i
);

  logic                   l2_req;
  logic                   ctrl_req;
  logic                   uart_req;
  logic                   tgt_we;
  logic [`SOC_ADDR_W-1:0] tgt_addr;
  logic [`SOC_STRB_W-1:0] tgt_be;
  logic [`SOC_DATA_W-1:0] tgt_wdata;
  logic                   l2_rvalid;
  logic [`SOC_DATA_W-1:0] l2_rdata;
  logic                   ctrl_rvalid;
  logic [`SOC_DATA_W-1:0] ctrl_rdata;
  logic                   uart_done;
  logic [`SOC_DATA_W-1:0] uart_rdata;
  logic                   uart_err;

  soc_addr_decode i_decode (
    .clk_i        (clk_i        ),
    .reset_i      (reset_i      ),
    .host_req_i   (host_req_i   ),
    .host_we_i    (host_we_i    ),
    .host_addr_i  (host_addr_i  ),
    .host_be_i    (host_be_i    ),
    .host_wdata_i (host_wdata_i ),
    .host_gnt_o   (host_gnt_o   ),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o ),
    .host_err_o   (host_err_o   ),
    .l2_req_o     (l2_req       ),
    .ctrl_req_o   (ctrl_req     ),
    .uart_req_o   (uart_req     ),
    .tgt_we_o     (tgt_we       ),
    .tgt_addr_o   (tgt_addr     ),
    .tgt_be_o     (tgt_be       ),
    .tgt_wdata_o  (tgt_wdata    ),
    .l2_rvalid_i  (l2_rvalid    ),
    .l2_rdata_i   (l2_rdata     ),
    .ctrl_rvalid_i(ctrl_rvalid  ),
    .ctrl_rdata_i (ctrl_rdata   ),
    .uart_done_i  (uart_done    ),
    .uart_rdata_i (uart_rdata   ),
    .uart_err_i   (uart_err     )
  );

  // L2 is always ready, so its grant is the request
  soc_l2_mem i_l2 (
    .clk_i   (clk_i    ),
    .reset_i (reset_i  ),
    .req_i   (l2_req   ),
    .we_i    (tgt_we   ),
    .addr_i  (tgt_addr ),
    .be_i    (tgt_be   ),
    .wdata_i (tgt_wdata),
    .rvalid_o(l2_rvalid),
    .rdata_o (l2_rdata )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (tgt_we     ),
    .addr_i     (tgt_addr   ),
    .be_i       (tgt_be     ),
    .wdata_i    (tgt_wdata  ),
    .rvalid_o   (ctrl_rvalid),
    .rdata_o    (ctrl_rdata ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  soc_apb_bridge i_uart_bridge (
    .clk_i         (clk_i         ),
    .reset_i       (reset_i       ),
    .req_i         (uart_req      ),
    .we_i          (tgt_we        ),
    .addr_i        (tgt_addr      ),
    .wdata_i       (tgt_wdata     ),
    .done_o        (uart_done     ),
    .rdata_o       (uart_rdata    ),
    .err_o         (uart_err      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

endmodule : soc_top

/* source/soc_apb_bridge.sv */
// APB master bridge for the UART window
// IDLE, SETUP, ACCESS FSM with one-cycle completion pulse

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_apb_bridge import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Decoder side
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`SOC_ADDR_W-1:0]     addr_i,
  input  logic [`SOC_DATA_W-1:0]     wdata_i,
  output logic                       done_o,
  output logic [`SOC_DATA_W-1:0]     rdata_o,
  output logic                       err_o,
  // APB master
  output logic                       uart_psel_o,
  output logic                       uart_penable_o,
  output logic                       uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0]     uart_paddr_o,
  output logic [`SOC_APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [`SOC_APB_DATA_W-1:0] uart_prdata_i,
  input  logic                       uart_pready_i,
  input  logic                       uart_pslverr_i
);

  apb_state_e                 state_q;
  apb_state_e                 state_d;
  logic                       pwrite_q;
  logic [`SOC_ADDR_W-1:0]     paddr_q;
  logic [`SOC_APB_DATA_W-1:0] pwdata_q;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req_i) begin
          state_d = S_SETUP;
        end
      end
      S_SETUP:  state_d = S_ACCESS;
      S_ACCESS: begin
        if (uart_pready_i) begin
          state_d = S_IDLE;
        end
      end
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Transfer fields held from SETUP through ACCESS
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && req_i) begin
      pwrite_q <= we_i;
      paddr_q  <= addr_i;
      pwdata_q <= wdata_i[`SOC_APB_DATA_W-1:0];
    end
  end

  assign uart_psel_o    = (state_q != S_IDLE);
  assign uart_penable_o = (state_q == S_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  // Completion in the cycle pready is seen
  assign done_o  = (state_q == S_ACCESS) && uart_pready_i;
  assign rdata_o = {{(`SOC_DATA_W-`SOC_APB_DATA_W){1'b0}}, uart_prdata_i};
  assign err_o   = done_o && uart_pslverr_i;

endmodule : soc_apb_bridge

/* source/soc_ctrl_regs.sv */
// Control-register block
// Exit and counter-enable registers with byte-enable writes and read-back

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_ctrl_regs import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  input  logic [`SOC_STRB_W-1:0] be_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  output logic                   rvalid_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);

  localparam int unsigned OfsW = $clog2(`SOC_CTRL_LEN);

  logic [OfsW-1:0]        ofs;
  ctrl_reg_e              sel;
  logic                   hit;
  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] cnt_q;
  logic                   rvalid_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  assign ofs = addr_i[OfsW-1:0];

  // Register select by offset
  always_comb begin
    sel = R_EXIT;
    hit = 1'b0;
    if (ofs == `SOC_CTRL_EXIT_OFS) begin
      hit = 1'b1;
    end else if (ofs == `SOC_CTRL_CNT_OFS) begin
      sel = R_CNT_EN;
      hit = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i && we_i && hit) begin
        if (sel == R_EXIT) begin
          exit_q <= be_merge(exit_q, wdata_i, be_i);
        end else begin
          cnt_q <= be_merge(cnt_q, wdata_i, be_i);
        end
      end
    end
  end

  // Read data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (!hit) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= (sel == R_EXIT) ? exit_q : cnt_q;
      end
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_q;

endmodule : soc_ctrl_regs

/* source/soc_l2_mem.sv */
// Single-port L2 SRAM
// Byte-enable writes, registered reads, one-cycle read valid

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_l2_mem import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  input  logic [`SOC_STRB_W-1:0] be_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  output logic                   rvalid_o,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int unsigned IdxW = $clog2(`SOC_L2_WORDS);
  localparam int unsigned OfsW = $clog2(`SOC_STRB_W);

  logic [`SOC_DATA_W-1:0] mem [`SOC_L2_WORDS];
  logic [IdxW-1:0]        idx;
  logic                   rvalid_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  // Word index inside the DRAM window
  assign idx = addr_i[IdxW+OfsW-1:OfsW];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= be_merge(mem[idx], wdata_i, be_i);
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  // One-cycle latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : soc_l2_mem

/* source/soc_addr_decode.sv */
// Address decoder for the host request bus
// Target select, grant, and in-order response return

`timescale 1ns/1ps

`include "soc_params.svh"

module soc_addr_decode import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Host side
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  logic [`SOC_ADDR_W-1:0] host_addr_i,
  input  logic [`SOC_STRB_W-1:0] host_be_i,
  input  logic [`SOC_DATA_W-1:0] host_wdata_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output logic [`SOC_DATA_W-1:0] host_rdata_o,
  output logic                   host_err_o,
  // Target side
  output logic                   l2_req_o,
  output logic                   ctrl_req_o,
  output logic                   uart_req_o,
  output logic                   tgt_we_o,
  output logic [`SOC_ADDR_W-1:0] tgt_addr_o,
  output logic [`SOC_STRB_W-1:0] tgt_be_o,
  output logic [`SOC_DATA_W-1:0] tgt_wdata_o,
  input  logic                   l2_rvalid_i,
  input  logic [`SOC_DATA_W-1:0] l2_rdata_i,
  input  logic                   ctrl_rvalid_i,
  input  logic [`SOC_DATA_W-1:0] ctrl_rdata_i,
  input  logic                   uart_done_i,
  input  logic [`SOC_DATA_W-1:0] uart_rdata_i,
  input  logic                   uart_err_i
);

  soc_target_e            target;
  soc_target_e            tgt_q;
  logic                   rd_q;
  logic                   none_pend_q;
  logic                   uart_vld_q;
  logic                   uart_err_q;
  logic [`SOC_DATA_W-1:0] uart_rdata_q;

  //////////////////////////////
  // Request routing
  //////////////////////////////

  always_comb begin
    if (host_addr_i >= `SOC_DRAM_BASE && host_addr_i < `SOC_DRAM_BASE + `SOC_DRAM_LEN) begin
      target = T_L2;
    end else if (host_addr_i >= `SOC_UART_BASE &&
                 host_addr_i < `SOC_UART_BASE + `SOC_UART_LEN) begin
      target = T_UART;
    end else if (host_addr_i >= `SOC_CTRL_BASE &&
                 host_addr_i < `SOC_CTRL_BASE + `SOC_CTRL_LEN) begin
      target = T_CTRL;
    end else begin
      target = T_NONE;
    end
  end

  assign l2_req_o    = host_req_i && (target == T_L2);
  assign ctrl_req_o  = host_req_i && (target == T_CTRL);
  assign uart_req_o  = host_req_i && (target == T_UART);
  assign tgt_we_o    = host_we_i;
  assign tgt_addr_o  = host_addr_i;
  assign tgt_be_o    = host_be_i;
  assign tgt_wdata_o = host_wdata_i;

  // UART waits for the APB completion while other targets are granted at once
  assign host_gnt_o = host_req_i && ((target != T_UART) || uart_done_i);

  //////////////////////////////
  // Response return
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgt_q       <= T_NONE;
      rd_q        <= 1'b0;
      none_pend_q <= 1'b0;
      uart_vld_q  <= 1'b0;
    end else begin
      none_pend_q <= host_gnt_o && (target == T_NONE);
      uart_vld_q  <= uart_done_i;
      if (host_gnt_o) begin
        tgt_q <= target;
        rd_q  <= !host_we_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (uart_done_i) begin
      uart_rdata_q <= uart_rdata_i;
      uart_err_q   <= uart_err_i;
    end
  end

  assign host_rvalid_o = l2_rvalid_i || ctrl_rvalid_i || uart_vld_q || none_pend_q;

  always_comb begin
    host_rdata_o = '0;
    host_err_o   = 1'b0;
    case (tgt_q)
      T_L2:    host_rdata_o = l2_rdata_i;
      T_CTRL:  host_rdata_o = ctrl_rdata_i;
      T_UART: begin
        host_rdata_o = uart_rdata_q;
        host_err_o   = uart_vld_q && uart_err_q;
      end
      default: host_err_o = none_pend_q;
    endcase
    // Writes answer with zero data
    if (!rd_q) begin
      host_rdata_o = '0;
    end
  end

endmodule : soc_addr_decode

/* source/soc_pkg.sv */
// Shared SoC types
// Target select, control-register select and APB bridge states
// Byte-enable merge helper for the 64-bit targets

`include "soc_params.svh"

package soc_pkg;

  typedef enum logic [1:0] {
    T_L2,
    T_UART,
    T_CTRL,
    T_NONE
  } soc_target_e;

  typedef enum logic {
    R_EXIT,
    R_CNT_EN
  } ctrl_reg_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_ACCESS
  } apb_state_e;

  // Replace the enabled bytes of a word
  function automatic logic [`SOC_DATA_W-1:0] be_merge(
    input logic [`SOC_DATA_W-1:0] old_word,
    input logic [`SOC_DATA_W-1:0] new_word,
    input logic [`SOC_STRB_W-1:0] be
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < `SOC_STRB_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage : soc_pkg

/* source/soc_params.svh */
// Shared width, memory map and L2 size macros for the SoC interconnect
// Host bus, UART window and control-register offsets

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Host bus
`define SOC_ADDR_W        32
`define SOC_DATA_W        64
`define SOC_STRB_W        8
`define SOC_APB_DATA_W    32

// L2 depth in 64-bit words
`define SOC_L2_WORDS      1024

// Memory map
`define SOC_DRAM_BASE     32'h8000_0000
`define SOC_DRAM_LEN      (`SOC_L2_WORDS * `SOC_STRB_W)
`define SOC_UART_BASE     32'hC000_0000
`define SOC_UART_LEN      32'h0000_1000
`define SOC_CTRL_BASE     32'hD000_0000
`define SOC_CTRL_LEN      32'h0000_1000

// Control register offsets
`define SOC_CTRL_EXIT_OFS 'h0
`define SOC_CTRL_CNT_OFS  'h8

`endif
